// File: logic/predecode_pkg.sv
// shared constants and types for the predecoder
// instruction fields use the usual PowerPC layout, word bit 31 is ISA bit 0
// only the supported subset of opcodes is listed here
// spr constants hold the spr field as encoded in the word (halves swapped)

package predecode_pkg;

  // ----------------------------------------------------------------------
  // field widths
  // ----------------------------------------------------------------------
  localparam int inst_w    = 32;
  localparam int reg_idx_w = 5;
  localparam int cr_fields = 8;
  localparam int seq_w     = 5;
  localparam int opcd_w    = 6;
  localparam int xo_w      = 10;
  localparam int spr_w     = 10;

  // register file size, bounds lmw/stmw sequencing
  localparam int num_gprs = 32;

  // ----------------------------------------------------------------------
  // shared types
  // ----------------------------------------------------------------------
  typedef logic [inst_w-1:0]    inst_t;
  typedef logic [reg_idx_w-1:0] reg_index_t;
  // bit i marks condition register field i
  typedef logic [cr_fields-1:0] cr_mask_t;
  typedef logic [seq_w-1:0]     seq_ctr_t;

  // ----------------------------------------------------------------------
  // primary opcodes
  // ----------------------------------------------------------------------
  localparam logic [opcd_w-1:0] op_cmpi   = 6'd11;
  localparam logic [opcd_w-1:0] op_addi   = 6'd14;
  localparam logic [opcd_w-1:0] op_addis  = 6'd15;
  localparam logic [opcd_w-1:0] op_bc     = 6'd16;
  // also carries bcctr, told apart by the extended opcode
  localparam logic [opcd_w-1:0] op_bclr   = 6'd19;
  localparam logic [opcd_w-1:0] op_ori    = 6'd24;
  localparam logic [opcd_w-1:0] op_alu_xo = 6'd31;
  localparam logic [opcd_w-1:0] op_lwz    = 6'd32;
  localparam logic [opcd_w-1:0] op_lwzu   = 6'd33;
  localparam logic [opcd_w-1:0] op_stw    = 6'd36;
  localparam logic [opcd_w-1:0] op_stwu   = 6'd37;
  localparam logic [opcd_w-1:0] op_lmw    = 6'd46;
  localparam logic [opcd_w-1:0] op_stmw   = 6'd47;

  // ----------------------------------------------------------------------
  // extended opcodes, word bits 10:1
  // ----------------------------------------------------------------------
  localparam logic [xo_w-1:0] xop_cmp    = 10'd0;
  // add matches only with OE clear
  localparam logic [xo_w-1:0] xop_add    = 10'd266;
  localparam logic [xo_w-1:0] xop_mfspr  = 10'd339;
  localparam logic [xo_w-1:0] xop_mtspr  = 10'd467;
  localparam logic [xo_w-1:0] xxop_bclr  = 10'd16;
  localparam logic [xo_w-1:0] xxop_bcctr = 10'd528;

  // spr 8 (link) and spr 9 (count), low half first as in the word
  localparam logic [spr_w-1:0] spr_lnk = 10'b01000_00000;
  localparam logic [spr_w-1:0] spr_ctr = 10'b01001_00000;

endpackage

// File: logic/gpr_fields_if.sv
`timescale 1ns/1ps
// register operand predecode result for one step
// driven combinationally by the gpr decoder

interface gpr_fields_if;
  import predecode_pkg::*;

  logic       read_ra;
  logic       read_rb;
  logic       read_rt;
  logic       write_ra;
  logic       write_rt;
  reg_index_t ra;
  reg_index_t rb;
  reg_index_t rt;
  // operand b comes from the immediate field
  logic       b_immediate;

  modport producer (output read_ra, read_rb, read_rt, write_ra, write_rt,
                    output ra, rb, rt, b_immediate);
  modport consumer (input read_ra, read_rb, read_rt, write_ra, write_rt,
                    input ra, rb, rt, b_immediate);

endinterface

// File: logic/flow_fields_if.sv
`timescale 1ns/1ps
// branch resource predecode result, link/count/cr usage of one step
// driven combinationally by the flow decoder

interface flow_fields_if;
  import predecode_pkg::*;

  logic     read_lnk;
  logic     write_lnk;
  logic     read_ctr;
  logic     write_ctr;
  // one bit per cr field
  cr_mask_t read_cr;
  cr_mask_t write_cr;

  modport producer (output read_lnk, write_lnk, read_ctr, write_ctr,
                    output read_cr, write_cr);
  modport consumer (input read_lnk, write_lnk, read_ctr, write_ctr,
                    input read_cr, write_cr);

endinterface

// File: logic/gpr_decode.sv
`timescale 1ns/1ps
// register operand predecode, purely combinational
// cur_seq only matters for lwzu and lmw/stmw, other words must see step 0
// unsupported words give all flags zero, indices still follow the raw fields

module gpr_decode (
  input  predecode_pkg::inst_t    cur_inst,
  input  predecode_pkg::seq_ctr_t cur_seq,
  gpr_fields_if.producer          gpr
);
  import predecode_pkg::*;

  logic [opcd_w-1:0] opcd;
  logic [xo_w-1:0]   xo;
  reg_index_t        rt_f;
  reg_index_t        ra_f;
  reg_index_t        rb_f;
  logic              ra_nz;
  logic              upd_step;

  // ----------------------------------------------------------------------
  // field extraction
  // ----------------------------------------------------------------------
  assign opcd = cur_inst[31:26];
  assign rt_f = cur_inst[25:21];
  assign ra_f = cur_inst[20:16];
  assign rb_f = cur_inst[15:11];
  assign xo   = cur_inst[10:1];

  // ra = 0 means literal zero for d-form addressing and addi
  assign ra_nz = (ra_f != '0);

  // lwzu has two steps, any nonzero step is the ra update
  assign upd_step = (cur_seq != '0);

  // ----------------------------------------------------------------------
  // operand decode
  // ----------------------------------------------------------------------
  always_comb begin
    gpr.read_ra     = 1'b0;
    gpr.read_rb     = 1'b0;
    gpr.read_rt     = 1'b0;
    gpr.write_ra    = 1'b0;
    gpr.write_rt    = 1'b0;
    gpr.b_immediate = 1'b0;
    gpr.ra          = ra_f;
    gpr.rb          = rb_f;
    gpr.rt          = rt_f;

    case (opcd)
      op_addi, op_addis, op_lwz: begin
        gpr.read_ra     = ra_nz;
        gpr.write_rt    = 1'b1;
        gpr.b_immediate = 1'b1;
      end

      // logical immediate swaps roles, source sits in the rt field
      op_ori: begin
        gpr.read_ra     = 1'b1;
        gpr.write_rt    = 1'b1;
        gpr.b_immediate = 1'b1;
        gpr.ra          = rt_f;
        gpr.rt          = ra_f;
      end

      // step 0 loads, step 1 writes back the effective address
      op_lwzu: begin
        gpr.b_immediate = 1'b1;
        if (upd_step) begin
          gpr.write_ra = 1'b1;
        end else begin
          gpr.read_ra  = 1'b1;
          gpr.write_rt = 1'b1;
        end
      end

      op_stw, op_stwu: begin
        gpr.read_ra     = ra_nz;
        gpr.read_rt     = 1'b1;
        gpr.b_immediate = 1'b1;
        gpr.write_ra    = (opcd == op_stwu);
      end

      // one register per step, rt walks up from the base register
      op_lmw, op_stmw: begin
        gpr.read_ra     = ra_nz;
        gpr.write_rt    = (opcd == op_lmw);
        gpr.read_rt     = (opcd == op_stmw);
        gpr.b_immediate = 1'b1;
        gpr.rt          = rt_f + cur_seq;
      end

      op_cmpi: begin
        gpr.read_ra     = 1'b1;
        gpr.b_immediate = 1'b1;
      end

      // branch displacement counts as immediate operand
      op_bc: gpr.b_immediate = 1'b1;

      op_alu_xo: begin
        case (xo)
          xop_add: begin
            gpr.read_ra  = 1'b1;
            gpr.read_rb  = 1'b1;
            gpr.write_rt = 1'b1;
          end
          xop_cmp: begin
            gpr.read_ra = 1'b1;
            gpr.read_rb = 1'b1;
          end
          // spr moves route the gpr through the ra port
          xop_mfspr: begin
            gpr.write_ra = 1'b1;
            gpr.ra       = rt_f;
          end
          xop_mtspr: begin
            gpr.read_ra = 1'b1;
            gpr.ra      = rt_f;
          end
          default: ;
        endcase
      end

      default: ;
    endcase
  end

endmodule

// File: logic/flow_decode.sv
`timescale 1ns/1ps
// link, count and cr field predecode, purely combinational
// bo[4] set means the cr is not tested, bo[2] set means ctr is left alone
// only spr 8 and 9 are recognised for mfspr/mtspr

module flow_decode (
  input  predecode_pkg::inst_t cur_inst,
  flow_fields_if.producer      flow
);
  import predecode_pkg::*;

  logic [opcd_w-1:0] opcd;
  logic [xo_w-1:0]   xo;
  logic [spr_w-1:0]  spr;
  logic [4:0]        bo;
  logic [2:0]        bi_fld;
  logic [2:0]        bf_fld;
  logic              lk;
  logic              rc;
  logic              ctr_dec;
  cr_mask_t          br_cr;

  // 3-to-8 decode of a cr field number
  function automatic cr_mask_t field_mask(input logic [2:0] fld);
    cr_mask_t m;
    m      = '0;
    m[fld] = 1'b1;
    return m;
  endfunction

  // ----------------------------------------------------------------------
  // field extraction
  // ----------------------------------------------------------------------
  assign opcd   = cur_inst[31:26];
  assign bo     = cur_inst[25:21];
  assign bf_fld = cur_inst[25:23];
  assign bi_fld = cur_inst[20:18];
  assign spr    = cur_inst[20:11];
  assign xo     = cur_inst[10:1];
  // lk for branches, rc for record forms, same bit
  assign lk     = cur_inst[0];
  assign rc     = cur_inst[0];

  // conditional branches decrement ctr unless bo[2] is set
  assign ctr_dec = ~bo[2];
  // cr field tested by a conditional branch
  assign br_cr   = bo[4] ? '0 : field_mask(bi_fld);

  // ----------------------------------------------------------------------
  // resource decode
  // ----------------------------------------------------------------------
  always_comb begin
    flow.read_lnk  = 1'b0;
    flow.write_lnk = 1'b0;
    flow.read_ctr  = 1'b0;
    flow.write_ctr = 1'b0;
    flow.read_cr   = '0;
    flow.write_cr  = '0;

    case (opcd)
      op_bc: begin
        flow.write_lnk = lk;
        flow.read_ctr  = ctr_dec;
        flow.write_ctr = ctr_dec;
        flow.read_cr   = br_cr;
      end

      op_bclr: begin
        if (xo == xxop_bclr) begin
          flow.read_lnk  = 1'b1;
          flow.write_lnk = lk;
          flow.read_ctr  = ctr_dec;
          flow.write_ctr = ctr_dec;
          flow.read_cr   = br_cr;
        end else if (xo == xxop_bcctr) begin
          // target comes from ctr, so it is read but never decremented
          flow.write_lnk = lk;
          flow.read_ctr  = 1'b1;
          flow.read_cr   = br_cr;
        end
      end

      // compares write the field named by bf
      op_cmpi: flow.write_cr = field_mask(bf_fld);

      op_alu_xo: begin
        case (xo)
          xop_add:   flow.write_cr = cr_mask_t'(rc);
          xop_cmp:   flow.write_cr = field_mask(bf_fld);
          xop_mfspr: begin
            flow.read_lnk = (spr == spr_lnk);
            flow.read_ctr = (spr == spr_ctr);
          end
          xop_mtspr: begin
            flow.write_lnk = (spr == spr_lnk);
            flow.write_ctr = (spr == spr_ctr);
          end
          default: ;
        endcase
      end

      default: ;
    endcase
  end

endmodule

// File: logic/predec_sequencer.sv
`timescale 1ns/1ps
// latches a fetched word and walks through its steps, one record per cycle
// a new strobe is only taken while busy is low, strobes during busy are dropped
// lwzu gives 2 steps, lmw/stmw give 32 - rt, everything else 1

module predec_sequencer (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      inst_valid,
  input  predecode_pkg::inst_t      inst,
  output predecode_pkg::inst_t      cur_inst,
  output predecode_pkg::seq_ctr_t   cur_seq,
  gpr_fields_if.consumer            gpr,
  flow_fields_if.consumer           flow,
  output logic                      busy,
  output logic                      pd_valid,
  output predecode_pkg::seq_ctr_t   pd_seq,
  output logic                      read_ra,
  output logic                      read_rb,
  output logic                      read_rt,
  output logic                      write_ra,
  output logic                      write_rt,
  output predecode_pkg::reg_index_t ra,
  output predecode_pkg::reg_index_t rb,
  output predecode_pkg::reg_index_t rt,
  output logic                      b_immediate,
  output logic                      read_lnk,
  output logic                      write_lnk,
  output logic                      read_ctr,
  output logic                      write_ctr,
  output predecode_pkg::cr_mask_t   read_cr,
  output predecode_pkg::cr_mask_t   write_cr
);
  import predecode_pkg::*;

  inst_t             inst_q;
  seq_ctr_t          seq_q;
  seq_ctr_t          last_q;
  seq_ctr_t          last_step;
  logic [opcd_w-1:0] opcd_in;
  logic              accept;
  logic              step_en;

  // ----------------------------------------------------------------------
  // step count of the incoming word
  // ----------------------------------------------------------------------
  assign opcd_in = inst[31:26];

  // kept as count minus one, so 32 steps of lmw r0 fit in 5 bits
  always_comb begin
    case (opcd_in)
      op_lwzu:         last_step = seq_ctr_t'(1);
      op_lmw, op_stmw: last_step = seq_ctr_t'(num_gprs - 1) - inst[25:21];
      default:         last_step = '0;
    endcase
  end

  // ----------------------------------------------------------------------
  // step control
  // ----------------------------------------------------------------------
  assign accept  = inst_valid & ~busy;
  // a record is produced on every accepted strobe and every busy cycle
  assign step_en = accept | busy;

  // idle: decode the live word as step 0, busy: replay latched word
  assign cur_inst = busy ? inst_q : inst;
  assign cur_seq  = busy ? seq_q : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy   <= 1'b0;
      seq_q  <= '0;
      last_q <= '0;
    end else if (accept) begin
      busy   <= (last_step != '0);
      seq_q  <= seq_ctr_t'(1);
      last_q <= last_step;
    end else if (busy) begin
      // drop busy as the last step is registered
      busy  <= (seq_q != last_q);
      seq_q <= seq_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      inst_q <= inst;
    end
  end

  // ----------------------------------------------------------------------
  // registered predecode record
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      pd_valid    <= 1'b0;
      read_ra     <= 1'b0;
      read_rb     <= 1'b0;
      read_rt     <= 1'b0;
      write_ra    <= 1'b0;
      write_rt    <= 1'b0;
      b_immediate <= 1'b0;
      read_lnk    <= 1'b0;
      write_lnk   <= 1'b0;
      read_ctr    <= 1'b0;
      write_ctr   <= 1'b0;
      read_cr     <= '0;
      write_cr    <= '0;
    end else begin
      pd_valid <= step_en;
      if (step_en) begin
        read_ra     <= gpr.read_ra;
        read_rb     <= gpr.read_rb;
        read_rt     <= gpr.read_rt;
        write_ra    <= gpr.write_ra;
        write_rt    <= gpr.write_rt;
        b_immediate <= gpr.b_immediate;
        read_lnk    <= flow.read_lnk;
        write_lnk   <= flow.write_lnk;
        read_ctr    <= flow.read_ctr;
        write_ctr   <= flow.write_ctr;
        read_cr     <= flow.read_cr;
        write_cr    <= flow.write_cr;
      end
    end
  end

  // indices and step number only mean something with pd_valid
  always_ff @(posedge clk) begin
    if (step_en) begin
      pd_seq <= cur_seq;
      ra     <= gpr.ra;
      rb     <= gpr.rb;
      rt     <= gpr.rt;
    end
  end

  // ----------------------------------------------------------------------
  // checks
  // ----------------------------------------------------------------------
  // fetch must hold off while a multi-step word is being sequenced
  a_no_strobe_busy: assert property (@(posedge clk) disable iff (reset)
    busy |-> !inst_valid)
    else $error("strobe while busy, word ignored");

  // the step counter never walks past the last step of the latched word
  a_step_bound: assert property (@(posedge clk) disable iff (reset)
    busy |-> (seq_q <= last_q))
    else $error("step counter ran past the last step");

endmodule

// File: logic/predecoder.sv
`timescale 1ns/1ps
// instruction predecoder top, one fetched word per inst_valid strobe
// records appear one cycle after the strobe, one per step on back-to-back cycles
// inst_valid must stay low while busy is high, there is no output back-pressure

module predecoder (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      inst_valid,
  input  predecode_pkg::inst_t      inst,
  output logic                      busy,
  output logic                      pd_valid,
  output predecode_pkg::seq_ctr_t   pd_seq,
  output logic                      read_ra,
  output logic                      read_rb,
  output logic                      read_rt,
  output logic                      write_ra,
  output logic                      write_rt,
  output predecode_pkg::reg_index_t ra,
  output predecode_pkg::reg_index_t rb,
  output predecode_pkg::reg_index_t rt,
  output logic                      b_immediate,
  output logic                      read_lnk,
  output logic                      write_lnk,
  output logic                      read_ctr,
  output logic                      write_ctr,
  output predecode_pkg::cr_mask_t   read_cr,
  output predecode_pkg::cr_mask_t   write_cr
);
  import predecode_pkg::*;

  // word and step seen by both decoders
  inst_t    cur_inst;
  seq_ctr_t cur_seq;

  gpr_fields_if  gpr_if ();
  flow_fields_if flow_if ();

  gpr_decode u_gpr_decode (
    .cur_inst (cur_inst),
    .cur_seq  (cur_seq),
    .gpr      (gpr_if)
  );

  flow_decode u_flow_decode (
    .cur_inst (cur_inst),
    .flow     (flow_if)
  );

  predec_sequencer u_predec_sequencer (
    .clk         (clk),
    .reset       (reset),
    .inst_valid  (inst_valid),
    .inst        (inst),
    .cur_inst    (cur_inst),
    .cur_seq     (cur_seq),
    .gpr         (gpr_if),
    .flow        (flow_if),
    .busy        (busy),
    .pd_valid    (pd_valid),
    .pd_seq      (pd_seq),
    .read_ra     (read_ra),
    .read_rb     (read_rb),
    .read_rt     (read_rt),
    .write_ra    (write_ra),
    .write_rt    (write_rt),
    .ra          (ra),
    .rb          (rb),
    .rt          (rt),
    .b_immediate (b_immediate),
    .read_lnk    (read_lnk),
    .write_lnk   (write_lnk),
    .read_ctr    (read_ctr),
    .write_ctr   (write_ctr),
    .read_cr     (read_cr),
    .write_cr    (write_cr)
  );

endmodule

// File: verification/tb_predecoder.sv
`timescale 1ns/1ps
// directed testbench for the predecoder top level
// inputs change on the falling edge and outputs are sampled there too
// expected records come from a reference model of the instruction rules
// a new word is only strobed while the dut is idle

module tb_predecoder;
  import predecode_pkg::*;

  // ------------------------------------------------------------------
  // run limits
  // ------------------------------------------------------------------
  localparam int max_insts = 40;
  // worst case is 32 records per word plus strobe and idle cycles
  localparam int timeout_cycles = 3 + max_insts * (num_gprs + 2) + 50;

  // one predecode record as seen on the top level ports
  typedef struct packed {
    seq_ctr_t   seq;
    logic       read_ra;
    logic       read_rb;
    logic       read_rt;
    logic       write_ra;
    logic       write_rt;
    reg_index_t ra;
    reg_index_t rb;
    reg_index_t rt;
    logic       b_imm;
    logic       read_lnk;
    logic       write_lnk;
    logic       read_ctr;
    logic       write_ctr;
    cr_mask_t   read_cr;
    cr_mask_t   write_cr;
  } rec_t;

  logic       clk = 1'b0;
  logic       reset;
  logic       inst_valid;
  inst_t      inst;
  logic       busy;
  logic       pd_valid;
  seq_ctr_t   pd_seq;
  logic       read_ra, read_rb, read_rt, write_ra, write_rt;
  reg_index_t ra, rb, rt;
  logic       b_immediate;
  logic       read_lnk, write_lnk, read_ctr, write_ctr;
  cr_mask_t   read_cr, write_cr;

  int          errors      = 0;
  int          checks      = 0;
  int          cycle_count = 0;
  logic [31:0] lcg_state   = 32'hb520;
  string       cur_test    = "none";

  predecoder u_predecoder (
    .clk (clk), .reset (reset), .inst_valid (inst_valid), .inst (inst),
    .busy (busy), .pd_valid (pd_valid), .pd_seq (pd_seq),
    .read_ra (read_ra), .read_rb (read_rb), .read_rt (read_rt),
    .write_ra (write_ra), .write_rt (write_rt),
    .ra (ra), .rb (rb), .rt (rt), .b_immediate (b_immediate),
    .read_lnk (read_lnk), .write_lnk (write_lnk),
    .read_ctr (read_ctr), .write_ctr (write_ctr),
    .read_cr (read_cr), .write_cr (write_cr)
  );

  // 20 ns clock
  always #10 clk = ~clk;

  // watchdog on the whole run
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout, run still going after %0d cycles", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  // ------------------------------------------------------------------
  // stimulus helpers
  // ------------------------------------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_reg();
    logic [31:0] v;
    v = lcg_next();
    return int'(v[27:23]);
  endfunction

  // op | rt/bo | ra/bi | 16-bit immediate
  function automatic inst_t d_form(input int op, input int rt, input int ra, input int imm);
    return {op[5:0], rt[4:0], ra[4:0], imm[15:0]};
  endfunction

  // op | rt | ra | rb | xo | rc/lk
  function automatic inst_t x_form(input int op, input int rt, input int ra, input int rb,
                                   input int xo, input int rc);
    return {op[5:0], rt[4:0], ra[4:0], rb[4:0], xo[9:0], rc[0]};
  endfunction

  // ------------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------------
  function automatic int step_count(input inst_t w);
    case (w[31:26])
      6'd33:        return 2;
      6'd46, 6'd47: return 32 - int'(w[25:21]);
      default:      return 1;
    endcase
  endfunction

  function automatic rec_t expect_rec(input inst_t w, input int k);
    rec_t       r;
    logic [4:0] f_rt;
    logic [4:0] f_ra;
    logic [9:0] xo;
    logic [9:0] spr_num;
    logic       low_bit;
    logic       dec_ctr;
    cr_mask_t   br_cr;
    f_rt    = w[25:21];
    f_ra    = w[20:16];
    xo      = w[10:1];
    low_bit = w[0];
    // spr number with the two halves put back in order
    spr_num = {w[15:11], w[20:16]};
    // bo[4] clear tests cr field bi[4:2], bo[2] clear decrements ctr
    br_cr   = '0;
    if (!f_rt[4]) br_cr[f_ra[4:2]] = 1'b1;
    dec_ctr = !f_rt[2];
    r       = '0;
    r.seq   = seq_ctr_t'(k);
    r.ra    = f_ra;
    r.rb    = w[15:11];
    r.rt    = f_rt;
    case (w[31:26])
      6'd14, 6'd15, 6'd32: begin
        r.read_ra  = (f_ra != 0);
        r.write_rt = 1'b1;
        r.b_imm    = 1'b1;
      end
      6'd24: begin
        r.read_ra  = 1'b1;
        r.write_rt = 1'b1;
        r.b_imm    = 1'b1;
        r.ra       = f_rt;
        r.rt       = f_ra;
      end
      6'd33: begin
        r.b_imm    = 1'b1;
        r.read_ra  = (k == 0);
        r.write_rt = (k == 0);
        r.write_ra = (k != 0);
      end
      6'd36, 6'd37: begin
        r.read_ra  = (f_ra != 0);
        r.read_rt  = 1'b1;
        r.b_imm    = 1'b1;
        r.write_ra = (w[31:26] == 6'd37);
      end
      6'd46, 6'd47: begin
        r.read_ra  = (f_ra != 0);
        r.write_rt = (w[31:26] == 6'd46);
        r.read_rt  = (w[31:26] == 6'd47);
        r.b_imm    = 1'b1;
        r.rt       = reg_index_t'(int'(f_rt) + k);
      end
      6'd11: begin
        r.read_ra             = 1'b1;
        r.b_imm               = 1'b1;
        r.write_cr[f_rt[4:2]] = 1'b1;
      end
      6'd16: begin
        r.b_imm     = 1'b1;
        r.write_lnk = low_bit;
        r.read_ctr  = dec_ctr;
        r.write_ctr = dec_ctr;
        r.read_cr   = br_cr;
      end
      6'd19: begin
        if (xo == 10'd16) begin
          r.read_lnk  = 1'b1;
          r.write_lnk = low_bit;
          r.read_ctr  = dec_ctr;
          r.write_ctr = dec_ctr;
          r.read_cr   = br_cr;
        end else if (xo == 10'd528) begin
          r.write_lnk = low_bit;
          r.read_ctr  = 1'b1;
          r.read_cr   = br_cr;
        end
      end
      6'd31: begin
        if (xo == 10'd266) begin
          r.read_ra     = 1'b1;
          r.read_rb     = 1'b1;
          r.write_rt    = 1'b1;
          r.write_cr[0] = low_bit;
        end else if (xo == 10'd0) begin
          r.read_ra             = 1'b1;
          r.read_rb             = 1'b1;
          r.write_cr[f_rt[4:2]] = 1'b1;
        end else if (xo == 10'd339) begin
          r.write_ra = 1'b1;
          r.ra       = f_rt;
          r.read_lnk = (spr_num == 10'd8);
          r.read_ctr = (spr_num == 10'd9);
        end else if (xo == 10'd467) begin
          r.read_ra   = 1'b1;
          r.ra        = f_rt;
          r.write_lnk = (spr_num == 10'd8);
          r.write_ctr = (spr_num == 10'd9);
        end
      end
      default: ;
    endcase
    return r;
  endfunction

  function automatic rec_t sample_dut();
    return {pd_seq, read_ra, read_rb, read_rt, write_ra, write_rt, ra, rb, rt,
            b_immediate, read_lnk, write_lnk, read_ctr, write_ctr, read_cr, write_cr};
  endfunction

  // ------------------------------------------------------------------
  // checking
  // ------------------------------------------------------------------
  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_record(input rec_t e, input rec_t a);
    check_value("pd_seq", e.seq, a.seq);
    check_value("read_ra", e.read_ra, a.read_ra);
    check_value("read_rb", e.read_rb, a.read_rb);
    check_value("read_rt", e.read_rt, a.read_rt);
    check_value("write_ra", e.write_ra, a.write_ra);
    check_value("write_rt", e.write_rt, a.write_rt);
    check_value("ra", e.ra, a.ra);
    check_value("rb", e.rb, a.rb);
    check_value("rt", e.rt, a.rt);
    check_value("b_immediate", e.b_imm, a.b_imm);
    check_value("read_lnk", e.read_lnk, a.read_lnk);
    check_value("write_lnk", e.write_lnk, a.write_lnk);
    check_value("read_ctr", e.read_ctr, a.read_ctr);
    check_value("write_ctr", e.write_ctr, a.write_ctr);
    check_value("read_cr", e.read_cr, a.read_cr);
    check_value("write_cr", e.write_cr, a.write_cr);
  endtask

  // strobe one word and check every record it gives, starts and ends on a falling edge
  task automatic run_inst(input string name, input inst_t w);
    int n;
    int k;
    n          = step_count(w);
    cur_test   = name;
    inst       = w;
    inst_valid = 1'b1;
    @(negedge clk);
    inst_valid = 1'b0;
    // junk on the input bus shows that the word was latched
    inst       = lcg_next();
    for (k = 0; k < n; k++) begin
      if (!pd_valid) begin
        errors++;
        $display("%s: no pd_valid record for step %0d of %0d", name, k, n);
      end else begin
        check_record(expect_rec(w, k), sample_dut());
        check_value("busy", (k != n - 1), busy);
      end
      @(negedge clk);
    end
    if (pd_valid) begin
      errors++;
      $display("%s: extra pd_valid record after %0d steps", name, n);
    end
  endtask

  // ------------------------------------------------------------------
  // tests
  // ------------------------------------------------------------------
  task automatic test_reset_state();
    cur_test = "reset";
    check_value("pd_valid", 0, pd_valid);
    check_value("busy", 0, busy);
    check_value("flags", 0, {read_ra, read_rb, read_rt, write_ra, write_rt, b_immediate,
                             read_lnk, write_lnk, read_ctr, write_ctr, read_cr, write_cr});
  endtask

  task automatic test_imm_mem();
    run_inst("addi", d_form(14, rand_reg(), rand_reg(), lcg_next()));
    run_inst("addi_ra0", d_form(14, rand_reg(), 0, lcg_next()));
    run_inst("addis", d_form(15, rand_reg(), rand_reg(), lcg_next()));
    run_inst("lwz", d_form(32, rand_reg(), rand_reg(), lcg_next()));
    run_inst("stw", d_form(36, rand_reg(), rand_reg(), lcg_next()));
    run_inst("stwu", d_form(37, rand_reg(), rand_reg(), lcg_next()));
    run_inst("ori", d_form(24, rand_reg(), rand_reg(), lcg_next()));
  endtask

  task automatic test_load_update();
    run_inst("lwzu", d_form(33, rand_reg(), rand_reg(), lcg_next()));
    run_inst("lwzu_ra0", d_form(33, rand_reg(), 0, lcg_next()));
  endtask

  task automatic test_multiple();
    run_inst("lmw", d_form(46, rand_reg(), rand_reg(), lcg_next()));
    run_inst("stmw", d_form(47, rand_reg(), rand_reg(), lcg_next()));
    // longest and shortest register walks
    run_inst("lmw_r0", d_form(46, 0, rand_reg(), lcg_next()));
    run_inst("stmw_r31", d_form(47, 31, rand_reg(), lcg_next()));
  endtask

  task automatic test_reg_forms();
    run_inst("add", x_form(31, rand_reg(), rand_reg(), rand_reg(), 266, 0));
    run_inst("add_rc", x_form(31, rand_reg(), rand_reg(), rand_reg(), 266, 1));
    run_inst("cmp", x_form(31, rand_reg(), rand_reg(), rand_reg(), 0, 0));
    run_inst("cmpi", d_form(11, rand_reg(), rand_reg(), lcg_next()));
  endtask

  task automatic test_branches();
    int i;
    for (i = 0; i < 3; i++) begin
      run_inst("bc", d_form(16, rand_reg(), rand_reg(), lcg_next()));
      run_inst("bclr", x_form(19, rand_reg(), rand_reg(), 0, 16, rand_reg()));
      run_inst("bcctr", x_form(19, rand_reg(), rand_reg(), 0, 528, rand_reg()));
    end
  endtask

  task automatic test_spr_moves();
    run_inst("mflr", x_form(31, rand_reg(), 8, 0, 339, 0));
    run_inst("mfctr", x_form(31, rand_reg(), 9, 0, 339, 0));
    run_inst("mtlr", x_form(31, rand_reg(), 8, 0, 467, 0));
    run_inst("mtctr", x_form(31, rand_reg(), 9, 0, 467, 0));
    // spr 1 is outside the link and count pair
    run_inst("mfspr_other", x_form(31, rand_reg(), 1, 0, 339, 0));
    run_inst("mtspr_other", x_form(31, rand_reg(), 1, 0, 467, 0));
    // opcode 0 is not in the subset
    run_inst("unsupported", d_form(0, rand_reg(), rand_reg(), lcg_next()));
  endtask

  // ------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------
  initial begin
    reset      = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_reset_state();
    test_imm_mem();
    test_load_update();
    test_multiple();
    test_reg_forms();
    test_branches();
    test_spr_moves();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
logic/predecode_pkg.sv
logic/gpr_fields_if.sv
logic/flow_fields_if.sv
logic/gpr_decode.sv
logic/flow_decode.sv
logic/predec_sequencer.sv
logic/predecoder.sv
verification/tb_predecoder.sv

// File: Bender.yml
package:
  name: predecoder

sources:
  - files:
      - logic/predecode_pkg.sv
      - logic/gpr_fields_if.sv
      - logic/flow_fields_if.sv
      - logic/gpr_decode.sv
      - logic/flow_decode.sv
      - logic/predec_sequencer.sv
      - logic/predecoder.sv
  - target: test
    files:
      - verification/tb_predecoder.sv
